//--- filelist.f
+incdir+hw
hw/mem_types_pkg.sv
hw/lock_types_pkg.sv
hw/pri.sv
hw/dmemd.sv
hw/dmemr.sv
hw/main_mem.sv
hw/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

//--- hw/dmemd.sv
`include "mem_settings.svh"

// Main data memory.
// The read port is combinational, so a core sees its word in the same
// cycle as its read phase. Writes land on the falling edge of clk, in
// the middle of the write phase.

module dmemd
   import mem_types_pkg::*;
(
   input  logic     clk,
   input  word_t    wdat,
   input  mem_adr_t read_adr,
   input  mem_adr_t write_adr,
   input  logic     we,
   output word_t    rdat
);

   word_t mem [`MEM_WORDS];   // contents are undefined after power up.

   // ------------------------------
   // read port
   // ------------------------------

   assign rdat = mem[read_adr];

   // ------------------------------
   // write port
   // ------------------------------

   always_ff @(negedge clk) begin
      if (we) begin
         mem[write_adr] <= wdat;
      end
   end

endmodule

//--- hw/dmemr.sv
`include "mem_settings.svh"

// Mirror of the low part of the data memory.
// It receives the same writes as dmemd when they fall in its range and
// has a read port of its own for a peripheral.

module dmemr
   import mem_types_pkg::*;
(
   input  logic        clk,
   input  mirror_adr_t write_adr,
   input  word_t       wdat,
   input  logic        we,
   input  mirror_adr_t read_adr,
   output word_t       rdat
);

   word_t mem [`MIRROR_WORDS];

   assign rdat = mem[read_adr];   // peripheral read, no latency.

   // same edge as the main memory so both copies agree.
   always_ff @(negedge clk) begin
      if (we) begin
         mem[write_adr] <= wdat;
      end
   end

endmodule

//--- hw/lock_types_pkg.sv
`include "mem_settings.svh"

package lock_types_pkg;

   // index of one mutex bit.
   typedef logic [`LOCK_ADR_W-1:0] lock_adr_t;

   // the whole table, one bit per mutex, set while the mutex is held.
   typedef logic [`LOCK_COUNT-1:0] mutex_vec_t;

endpackage

//--- hw/main_mem.sv
`include "mem_settings.svh"

// Shared data memory for all cores.
// Holds the memory arbitration and the mutex arbitration side by side,
// the slot counter that rotates their priority, and the steering of the
// winning core's address and data into the two memories.

module main_mem
   import mem_types_pkg::*;
   import lock_types_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  mem_adr_t  read_adr [`NUM_CORES-1:0],
   input  mem_adr_t  write_adr [`NUM_CORES-1:0],
   input  word_t     write_dat [`NUM_CORES-1:0],
   input  core_vec_t write,
   input  core_vec_t read,
   input  core_vec_t write_request,
   input  core_vec_t read_request,
   input  lock_adr_t lock_adr [`NUM_CORES-1:0],
   input  core_vec_t lock_en,
   input  core_vec_t unlock_en,
   input  mirror_adr_t mirror_adr,
   output word_t     mem_dat,
   output core_vec_t mem_ac,
   output core_vec_t lock_ac,
   output word_t     mirror_dat
);

   core_id_t   slot;          // current head of the priority rotation.
   mutex_vec_t mutex;         // one bit per held mutex.

   core_id_t   wreq_sel;
   logic       wreq_valid;
   core_id_t   rreq_sel;
   logic       rreq_valid;
   core_id_t   wr_sel;
   logic       wr_valid;      // a write phase is active this cycle.
   core_id_t   rd_sel;
   logic       rd_valid;      // a read phase is active this cycle.
   core_id_t   lk_sel;
   logic       lk_valid;
   core_id_t   ul_sel;
   logic       ul_valid;

   core_vec_t  lock_free;     // lock requests whose mutex is clear.
   core_vec_t  write_ac;
   core_vec_t  read_ac;
   core_vec_t  enlock_ac;
   core_vec_t  unlock_ac;

   mem_adr_t   sel_write_adr;
   mem_adr_t   sel_read_adr;
   word_t      sel_write_dat;
   word_t      dmem_rdat;
   logic       mirror_we;

   // turns an encoder result into a one-hot grant vector.
   function automatic core_vec_t onehot(input core_id_t sel, input logic valid);
      core_vec_t vec;
      vec = '0;
      if (valid) begin
         vec[sel] = 1'b1;
      end
      return vec;
   endfunction

   // ------------------------------
   // memory arbitration
   // ------------------------------

   pri u_pri_write_req (.req(write_request), .slot(slot), .sel(wreq_sel), .valid(wreq_valid));
   pri u_pri_read_req  (.req(read_request),  .slot(slot), .sel(rreq_sel), .valid(rreq_valid));

   // The data phases are one per type already; these just find the core.
   pri u_pri_write (.req(write), .slot(slot), .sel(wr_sel), .valid(wr_valid));
   pri u_pri_read  (.req(read),  .slot(slot), .sel(rd_sel), .valid(rd_valid));

   assign write_ac = onehot(wreq_sel, wreq_valid);
   assign read_ac  = onehot(rreq_sel, rreq_valid);
   assign mem_ac   = write_ac | read_ac;   // a write and a read may both win.

   // ------------------------------
   // mutex arbitration
   // ------------------------------

   // A lock can only compete while its bit is clear.
   always_comb begin
      for (int i = 0; i < `NUM_CORES; i++) begin
         lock_free[i] = lock_en[i] & ~mutex[lock_adr[i]];
      end
   end

   pri u_pri_lock   (.req(lock_free), .slot(slot), .sel(lk_sel), .valid(lk_valid));
   pri u_pri_unlock (.req(unlock_en), .slot(slot), .sel(ul_sel), .valid(ul_valid));

   assign enlock_ac = onehot(lk_sel, lk_valid);
   assign unlock_ac = onehot(ul_sel, ul_valid);
   assign lock_ac   = enlock_ac | unlock_ac;

   // An unlock of the same index in the same cycle overrides the lock.
   always_ff @(negedge clk) begin
      if (reset) begin
         mutex <= '0;
      end else begin
         if (lk_valid) begin
            mutex[lock_adr[lk_sel]] <= 1'b1;
         end
         if (ul_valid) begin
            mutex[lock_adr[ul_sel]] <= 1'b0;
         end
      end
   end

   // ------------------------------
   // slot counter
   // ------------------------------

   always_ff @(negedge clk) begin
      if (reset) begin
         slot <= '0;
      end else if (slot == core_id_t'(`NUM_CORES - 1)) begin
         slot <= '0;
      end else begin
         slot <= slot + 1'b1;
      end
   end

   // ------------------------------
   // address and data steering
   // ------------------------------

   assign sel_write_adr = write_adr[wr_sel];
   assign sel_write_dat = write_dat[wr_sel];
   assign sel_read_adr  = read_adr[rd_sel];

   dmemd u_dmemd (
      .clk       (clk),
      .wdat      (sel_write_dat),
      .read_adr  (sel_read_adr),
      .write_adr (sel_write_adr),
      .we        (wr_valid),
      .rdat      (dmem_rdat)
   );

   // the shared data bus only carries a word during a read phase.
   assign mem_dat = rd_valid ? dmem_rdat : '0;

   // Only the low words have a copy in the mirror.
   assign mirror_we = wr_valid & (sel_write_adr < `MIRROR_WORDS);

   dmemr u_dmemr (
      .clk       (clk),
      .write_adr (mirror_adr_t'(sel_write_adr)),
      .wdat      (sel_write_dat),
      .we        (mirror_we),
      .read_adr  (mirror_adr),
      .rdat      (mirror_dat)
   );

endmodule

//--- hw/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ------------------------------
// core count and slot rotation
// ------------------------------

`define NUM_CORES 8
`define SLOT_W 3            // one core index, also the arbitration slot.

// ------------------------------
// memory geometry
// ------------------------------

`define MEM_ADR_W 16
`define MEM_WORDS 65536
`define MIRROR_WORDS 2048   // writes below this address are mirrored.

// ------------------------------
// mutex table
// ------------------------------

`define LOCK_ADR_W 10
`define LOCK_COUNT 1024

`endif

//--- hw/mem_subsystem_top.sv
`include "mem_settings.svh"

// Top level of the shared memory subsystem.
// Brings the per-core memory and mutex ports and the peripheral read
// port of the mirror out to the pins.

module mem_subsystem_top
   import mem_types_pkg::*;
   import lock_types_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  mem_adr_t    read_adr [`NUM_CORES-1:0],
   input  mem_adr_t    write_adr [`NUM_CORES-1:0],
   input  word_t       write_dat [`NUM_CORES-1:0],
   input  core_vec_t   write,
   input  core_vec_t   read,
   input  core_vec_t   write_request,
   input  core_vec_t   read_request,
   input  lock_adr_t   lock_adr [`NUM_CORES-1:0],
   input  core_vec_t   lock_en,
   input  core_vec_t   unlock_en,
   input  mirror_adr_t mirror_adr,
   output word_t       mem_dat,
   output core_vec_t   mem_ac,
   output core_vec_t   lock_ac,
   output word_t       mirror_dat
);

   // ------------------------------
   // shared memory
   // ------------------------------

   main_mem u_main_mem (
      .clk           (clk),
      .reset         (reset),
      .read_adr      (read_adr),
      .write_adr     (write_adr),
      .write_dat     (write_dat),
      .write         (write),
      .read          (read),
      .write_request (write_request),
      .read_request  (read_request),
      .lock_adr      (lock_adr),
      .lock_en       (lock_en),
      .unlock_en     (unlock_en),
      .mirror_adr    (mirror_adr),   // peripheral side of the mirror.
      .mem_dat       (mem_dat),
      .mem_ac        (mem_ac),
      .lock_ac       (lock_ac),
      .mirror_dat    (mirror_dat)
   );

endmodule

//--- hw/mem_types_pkg.sv
`include "mem_settings.svh"

package mem_types_pkg;

   // one data word as stored in the main memory and the mirror.
   typedef logic [15:0] word_t;

   // full address into the main memory.
   typedef logic [`MEM_ADR_W-1:0] mem_adr_t;

   // address into the mirror, which only covers the low words.
   typedef logic [$clog2(`MIRROR_WORDS)-1:0] mirror_adr_t;

   // index of a core.
   // The free-running arbitration slot uses the same type, so a slot
   // can be compared with or added to a core index directly.
   typedef logic [`SLOT_W-1:0] core_id_t;

   // one bit per core, for request and grant vectors.
   typedef logic [`NUM_CORES-1:0] core_vec_t;

endpackage

//--- hw/pri.sv
`include "mem_settings.svh"

// Rotating-priority encoder.
// The search starts at the current slot and wraps around, so every
// requester becomes the first candidate once per rotation.

module pri
   import mem_types_pkg::*;
(
   input  core_vec_t req,
   input  core_id_t  slot,
   output core_id_t  sel,
   output logic      valid
);

   // ------------------------------
   // cyclic scan
   // ------------------------------

   always_comb begin
      core_id_t idx;
      sel   = '0;
      valid = 1'b0;
      for (int k = 0; k < `NUM_CORES; k++) begin
         idx = slot + core_id_t'(k);   // wraps at the core count.
         if (!valid && req[idx]) begin
            sel   = idx;                // first hit wins.
            valid = 1'b1;
         end
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_mem_subsystem \
   -Mdir obj_dir -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "build or run failed, see sim.log"; exit 1; }

grep -qx "Finished with no errors" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

//--- test/tb_mem_subsystem.sv
`include "mem_settings.svh"

module tb_mem_subsystem
   import mem_types_pkg::*;
   import lock_types_pkg::*;
();

   localparam int CLK_PERIOD    = 100;
   localparam int GRANT_TIMEOUT = 20;   // cycles a core waits for any grant.

   logic        clk;
   logic        reset;
   mem_adr_t    read_adr [`NUM_CORES-1:0];
   mem_adr_t    write_adr [`NUM_CORES-1:0];
   word_t       write_dat [`NUM_CORES-1:0];
   core_vec_t   write;
   core_vec_t   read;
   core_vec_t   write_request;
   core_vec_t   read_request;
   lock_adr_t   lock_adr [`NUM_CORES-1:0];
   core_vec_t   lock_en;
   core_vec_t   unlock_en;
   mirror_adr_t mirror_adr;
   word_t       mem_dat;
   core_vec_t   mem_ac;
   core_vec_t   lock_ac;
   word_t       mirror_dat;

   word_t       mem_model [mem_adr_t];   // last word written to each address.
   bit          lock_model [`LOCK_COUNT];
   logic [31:0] lcg_state = 32'h983a5fe9;
   int          errors = 0;
   int          checks = 0;

   mem_subsystem_top u_dut (
      .clk           (clk),
      .reset         (reset),
      .read_adr      (read_adr),
      .write_adr     (write_adr),
      .write_dat     (write_dat),
      .write         (write),
      .read          (read),
      .write_request (write_request),
      .read_request  (read_request),
      .lock_adr      (lock_adr),
      .lock_en       (lock_en),
      .unlock_en     (unlock_en),
      .mirror_adr    (mirror_adr),
      .mem_dat       (mem_dat),
      .mem_ac        (mem_ac),
      .lock_ac       (lock_ac),
      .mirror_dat    (mirror_dat)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // helpers
   // ------------------------------

   // the low bits of an LCG repeat quickly, so only the upper bits go out.
   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {8'h00, lcg_state[31:8]};
   endfunction

   function automatic int first_set(input core_vec_t v);
      int idx;
      idx = -1;
      for (int k = `NUM_CORES - 1; k >= 0; k--) begin
         if (v[k]) idx = k;
      end
      return idx;
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Called right after driving at a rising edge. Grants are sampled a quarter
   // period later, before the slot moves on at the falling edge.
   task automatic wait_for_grant(input int core, input bit on_lock, output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (!ok && n < GRANT_TIMEOUT) begin
         #(CLK_PERIOD / 4);
         if (on_lock ? lock_ac[core] : mem_ac[core]) begin
            ok = 1'b1;
         end else begin
            @(posedge clk);
            n++;
         end
      end
      if (!ok) begin
         $display("ERROR: core %0d got no %s grant within %0d cycles",
                  core, on_lock ? "lock" : "memory", GRANT_TIMEOUT);
         errors++;
      end
   endtask

   task automatic do_write(input int core, input mem_adr_t adr, input word_t dat);
      bit ok;
      @(posedge clk);
      write_request[core] <= 1'b1;
      wait_for_grant(core, 1'b0, ok);
      @(posedge clk);
      write_request[core] <= 1'b0;
      if (ok) begin
         write[core]     <= 1'b1;   // one-cycle data phase.
         write_adr[core] <= adr;
         write_dat[core] <= dat;
         mem_model[adr] = dat;
         @(posedge clk);
         write[core] <= 1'b0;
      end
   endtask

   task automatic do_read(input string name, input int core, input mem_adr_t adr);
      bit ok;
      @(posedge clk);
      read_request[core] <= 1'b1;
      wait_for_grant(core, 1'b0, ok);
      @(posedge clk);
      read_request[core] <= 1'b0;
      if (ok) begin
         read[core]     <= 1'b1;
         read_adr[core] <= adr;
         #(CLK_PERIOD / 4);
         compare(name, mem_model[adr], mem_dat);
         @(posedge clk);
         read[core] <= 1'b0;
      end
   endtask

   // ------------------------------
   // tests
   // ------------------------------

   task automatic test_idle();
      @(posedge clk);
      #(CLK_PERIOD / 4);
      compare("idle mem_ac", 0, mem_ac);
      compare("idle lock_ac", 0, lock_ac);
   endtask

   task automatic test_write_read();
      mem_adr_t adrs [$];
      mem_adr_t adr;
      int       core;
      for (int k = 0; k < 12; k++) begin
         adr  = mem_adr_t'(next_random());
         core = next_random() % `NUM_CORES;
         do_write(core, adr, word_t'(next_random()));
         adrs.push_back(adr);
      end
      foreach (adrs[k]) begin
         do_read("write then read", next_random() % `NUM_CORES, adrs[k]);
      end
   endtask

   task automatic test_contention();
      core_vec_t requesters;
      core_vec_t req;
      core_vec_t g;
      int        waited [`NUM_CORES];
      bit        reading;
      bit        phase;       // a read phase runs in the cycle being sampled.
      mem_adr_t  phase_adr;
      mem_adr_t  adr;
      word_t     dat;
      mem_adr_t  adrs [$];
      int        owners [$];
      int        c;
      for (int round = 0; round < 3; round++) begin
         reading    = (round == 2);   // the last round reads what the others wrote.
         requesters = core_vec_t'(next_random()) | core_vec_t'(8'h81);   // at least two.
         req        = requesters;
         phase      = 1'b0;
         foreach (waited[i]) begin
            waited[i] = 0;
         end
         @(posedge clk);
         if (reading) begin
            read_request <= req;
         end else begin
            write_request <= req;
         end
         // winners drop out for their data phase and then request again.
         for (int cyc = 0; cyc < 3 * `NUM_CORES; cyc++) begin
            #(CLK_PERIOD / 4);
            g = mem_ac;
            if (phase) begin
               compare("contention read data", mem_model[phase_adr], mem_dat);
            end
            compare("contention one-hot", 1, $countones(g));
            compare("contention owner", 0, g & ~req);
            for (int i = 0; i < `NUM_CORES; i++) begin
               if (!req[i] || g[i]) begin
                  waited[i] = 0;
               end else begin
                  waited[i]++;
                  if (waited[i] == `NUM_CORES) begin
                     $display("ERROR: core %0d was passed over for %0d cycles",
                              i, waited[i]);
                     errors++;
                  end
               end
            end
            c     = first_set(g);
            req   = (cyc == 3 * `NUM_CORES - 1) ? '0 : requesters & ~g;
            phase = 1'b0;
            @(posedge clk);
            if (reading) begin
               read_request <= req;
               read         <= g;   // the winner's data phase.
            end else begin
               write_request <= req;
               write         <= g;
            end
            if (c >= 0 && reading) begin
               phase_adr = adrs[next_random() % adrs.size()];
               phase     = 1'b1;
               read_adr[c] <= phase_adr;
            end else if (c >= 0) begin
               adr = mem_adr_t'(next_random());
               dat = word_t'(next_random());
               write_adr[c] <= adr;
               write_dat[c] <= dat;
               mem_model[adr] = dat;
               adrs.push_back(adr);
               owners.push_back(c);
            end
         end
         #(CLK_PERIOD / 4);
         if (phase) begin
            compare("contention read data", mem_model[phase_adr], mem_dat);
         end
         @(posedge clk);
         write <= '0;
         read  <= '0;
      end
      foreach (adrs[k]) begin
         do_read("contention readback", owners[k], adrs[k]);
      end
   endtask

   task automatic test_locks();
      lock_adr_t idx;
      int        holder;
      int        waiter;
      bit        ok;
      idx    = lock_adr_t'(next_random());
      holder = 2;
      waiter = 6;
      @(posedge clk);
      lock_adr[holder] <= idx;
      lock_en[holder]  <= 1'b1;
      wait_for_grant(holder, 1'b1, ok);
      @(posedge clk);
      lock_en[holder] <= 1'b0;
      if (ok) lock_model[idx] = 1'b1;
      lock_adr[waiter] <= idx;
      lock_en[waiter]  <= 1'b1;
      // the waiter must stay out while the bit is held.
      repeat (10) begin
         #(CLK_PERIOD / 4);
         compare("lock held elsewhere", !lock_model[idx], lock_ac[waiter]);
         @(posedge clk);
      end
      unlock_en[holder] <= 1'b1;
      wait_for_grant(holder, 1'b1, ok);
      @(posedge clk);
      unlock_en[holder] <= 1'b0;
      if (ok) lock_model[idx] = 1'b0;
      wait_for_grant(waiter, 1'b1, ok);
      @(posedge clk);
      lock_en[waiter]   <= 1'b0;
      unlock_en[waiter] <= 1'b1;   // leave the table clear.
      if (ok) lock_model[idx] = 1'b1;
      wait_for_grant(waiter, 1'b1, ok);
      @(posedge clk);
      unlock_en[waiter] <= 1'b0;
      if (ok) lock_model[idx] = 1'b0;
   endtask

   task automatic test_mirror();
      mem_adr_t low;
      mem_adr_t high;
      low = mem_adr_t'(next_random() % `MIRROR_WORDS);
      do_write(1, low, word_t'(next_random()));
      @(posedge clk);
      mirror_adr <= mirror_adr_t'(low);
      #(CLK_PERIOD / 4);
      compare("mirror low write", mem_model[low], mirror_dat);
      // same mirror index, but above the mirrored range.
      high = low + mem_adr_t'(`MIRROR_WORDS * (1 + next_random() % 31));
      do_write(4, high, word_t'(next_random()));
      @(posedge clk);
      #(CLK_PERIOD / 4);
      compare("mirror high write", mem_model[low], mirror_dat);
      do_read("mirror high readback", 4, high);
   endtask

   // ------------------------------
   // sequence
   // ------------------------------

   initial begin
      reset         = 1'b1;
      write         = '0;
      read          = '0;
      write_request = '0;
      read_request  = '0;
      lock_en       = '0;
      unlock_en     = '0;
      mirror_adr    = '0;
      for (int i = 0; i < `NUM_CORES; i++) begin
         read_adr[i]  = '0;
         write_adr[i] = '0;
         write_dat[i] = '0;
         lock_adr[i]  = '0;
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      test_idle();
      test_write_read();
      test_contention();
      test_locks();
      test_mirror();
      test_mirror();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
